/* all.f */
+incdir+include
hdl/fnd_pkg.sv
hdl/scan_tick_gen.sv
hdl/digit_scanner.sv
hdl/hex_to_seg.sv
hdl/counter_display_top.sv
tb/tb_counter_display.sv

/* hdl/counter_display_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fnd_macros.svh"

// free-running counter shown on four seven-segment digits.
// only the upper 16 bits are displayed so a person can follow them
module counter_display_top #(
    parameter int COUNT_W      = `FND_COUNT_W,
    parameter int SCAN_DIV_BIT = `FND_SCAN_DIV_BIT
) (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     count_enable,
    output logic [`FND_DIGITS*4-1:0] frame,
    output fnd_pkg::seg_pattern_t    seg,
    output fnd_pkg::digit_sel_t      com
);

    import fnd_pkg::*;

    localparam int FRAME_W = `FND_DIGITS * 4;

    logic [COUNT_W-1:0] count;
    logic [FRAME_W-1:0] count_hi;
    logic               scan_tick;
    fnd_frame_u         frame_u;
    hex_digit_t         digit;

    ////////////////////////////////////////////////////////////////////////////
    // up counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            count <= '0;
        end else if (count_enable) begin
            count <= count + 1'b1;
        end
    end

    // slow half of the counter, the low bits change too fast to read
    assign count_hi = count[COUNT_W-1 -: FRAME_W];

    ////////////////////////////////////////////////////////////////////////////
    // scan timing
    ////////////////////////////////////////////////////////////////////////////

    scan_tick_gen #(
        .DIV_BIT   (SCAN_DIV_BIT)
    ) u_scan_tick_gen (
        .clk       (clk),
        .reset_p   (reset_p),
        .scan_tick (scan_tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // digit scan and frame latch
    ////////////////////////////////////////////////////////////////////////////

    digit_scanner u_digit_scanner (
        .clk       (clk),
        .reset_p   (reset_p),
        .scan_tick (scan_tick),
        .count_hi  (count_hi),
        .frame     (frame_u),
        .com       (com),
        .digit     (digit)
    );

    assign frame = frame_u.value;  // the latched word, not the raw count

    ////////////////////////////////////////////////////////////////////////////
    // segment decode
    ////////////////////////////////////////////////////////////////////////////

    hex_to_seg u_hex_to_seg (
        .digit     (digit),
        .seg       (seg)
    );

endmodule

`default_nettype wire

/* hdl/digit_scanner.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fnd_macros.svh"

// walks the active-low commons across the digits, one step per scan tick.
// a new frame is taken from the counter only when the scan comes back to
// the rightmost digit, so all four digits always show the same count
module digit_scanner (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     scan_tick,
    input  logic [`FND_DIGITS*4-1:0] count_hi,
    output fnd_pkg::fnd_frame_u      frame,
    output fnd_pkg::digit_sel_t      com,
    output fnd_pkg::hex_digit_t      digit
);

    import fnd_pkg::*;

    localparam int SEL_W = $clog2(`FND_DIGITS);

    digit_sel_t       com_next;
    fnd_frame_u       frame_next;
    logic [SEL_W-1:0] sel_idx;     // nibble index for com_next
    logic             wrap;        // scan is about to relight digit 0

    ////////////////////////////////////////////////////////////////////////////
    // ring counter next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (com)
            4'b1110: com_next = 4'b1101;
            4'b1101: com_next = 4'b1011;
            4'b1011: com_next = 4'b0111;
            4'b0111: com_next = `FND_COM_FIRST;
            default: com_next = `FND_COM_FIRST;  // recover from a bad pattern
        endcase
    end

    assign wrap = (com_next == `FND_COM_FIRST);

    // latch the whole frame at the wrap, hold it otherwise
    always_comb begin
        frame_next = frame;
        if (wrap) begin
            frame_next.value = count_hi;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // digit selection
    ////////////////////////////////////////////////////////////////////////////

    // the low common picks which nibble is lit
    always_comb begin
        case (com_next)
            4'b1110: sel_idx = 2'd0;
            4'b1101: sel_idx = 2'd1;
            4'b1011: sel_idx = 2'd2;
            4'b0111: sel_idx = 2'd3;
            default: sel_idx = 2'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    // com, frame and digit move on the same edge so they never disagree
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com   <= `FND_COM_FIRST;
            frame <= '0;
            digit <= '0;               // shows "0" out of reset
        end else if (scan_tick) begin
            com   <= com_next;
            frame <= frame_next;
            digit <= frame_next.digits[sel_idx];
        end
    end

endmodule

`default_nettype wire

/* hdl/fnd_pkg.sv */
`default_nettype none

`include "fnd_macros.svh"

package fnd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // display types
    ////////////////////////////////////////////////////////////////////////////

    // one hex value shown on a digit
    typedef logic [3:0] hex_digit_t;

    // a..g in bits 7..1, dp in bit 0, low lights the segment
    typedef logic [7:0] seg_pattern_t;

    // one common per digit, exactly one bit low at a time
    typedef logic [`FND_DIGITS-1:0] digit_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // frame word
    ////////////////////////////////////////////////////////////////////////////

    // the counter side sees a number, the scanner picks nibbles
    // element 0 of digits is the low nibble of value
    typedef union packed {
        logic [`FND_DIGITS*4-1:0] value;
        hex_digit_t [`FND_DIGITS-1:0] digits;
    } fnd_frame_u;

endpackage

`default_nettype wire

/* hdl/hex_to_seg.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fnd_macros.svh"

// hex value to active-low segment pattern, dp kept dark
module hex_to_seg (
    input  fnd_pkg::hex_digit_t   digit,
    output fnd_pkg::seg_pattern_t seg
);

    ////////////////////////////////////////////////////////////////////////////
    // glyph table
    ////////////////////////////////////////////////////////////////////////////

    // bit order abcdefg.dp, a zero lights the segment
    always_comb begin
        case (digit)
            4'h0: seg = 8'b0000_0011;
            4'h1: seg = 8'b1001_1111;
            4'h2: seg = 8'b0010_0101;
            4'h3: seg = 8'b0000_1101;
            4'h4: seg = 8'b1001_1001;
            4'h5: seg = 8'b0100_1001;
            4'h6: seg = 8'b0100_0001;
            4'h7: seg = 8'b0001_1011;  // a, b, c and the f serif
            4'h8: seg = 8'b0000_0001;
            4'h9: seg = 8'b0001_1001;

            // letters, lower case b and d so they differ from 8 and 0
            4'ha: seg = 8'b0001_0001;
            4'hb: seg = 8'b1100_0001;
            4'hc: seg = 8'b0110_0011;
            4'hd: seg = 8'b1000_0101;
            4'he: seg = 8'b0110_0001;
            4'hf: seg = 8'b0111_0001;

            default: seg = `FND_SEG_BLANK;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/scan_tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fnd_macros.svh"

// divides clk down and turns each rising edge of the divided bit into a
// single-cycle enable, so the scanner never runs on a derived clock
module scan_tick_gen #(
    parameter int DIV_BIT = `FND_SCAN_DIV_BIT
) (
    input  logic clk,
    input  logic reset_p,
    output logic scan_tick
);

    logic [DIV_BIT:0] clk_div;  // top bit is the slow square wave
    logic             ff_cur;
    logic             ff_old;

    ////////////////////////////////////////////////////////////////////////////
    // free-running divider
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clk_div <= '0;
        end else begin
            clk_div <= clk_div + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // two-stage edge detector
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            ff_cur <= 1'b0;
            ff_old <= 1'b0;
        end else begin
            ff_cur <= clk_div[DIV_BIT];
            ff_old <= ff_cur;        // one cycle behind ff_cur
        end
    end

    assign scan_tick = ff_cur & ~ff_old;  // rising edge only

endmodule

`default_nettype wire

/* include/fnd_macros.svh */
`ifndef FND_MACROS_SVH
`define FND_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// display geometry
////////////////////////////////////////////////////////////////////////////

`define FND_DIGITS 4             // digits on the board

////////////////////////////////////////////////////////////////////////////
// counter and scan defaults
////////////////////////////////////////////////////////////////////////////

`define FND_COUNT_W 32           // free-running counter width
`define FND_SCAN_DIV_BIT 16      // rising edge of this divider bit makes a scan tick

// digit commons are active low, bit 0 is the rightmost digit
`define FND_COM_FIRST 4'b1110

`define FND_SEG_BLANK 8'b1111_1111  // every segment and the dp dark

`endif

/* tb/tb_counter_display.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fnd_macros.svh"

module tb_counter_display;

    import fnd_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = 32;   // 4 ticks of 8 cycles with SCAN_DIV_BIT 2
    localparam int COM_CYCLES   = 8;

    logic                     clk;
    logic                     reset_p;
    logic                     count_enable;
    logic [`FND_DIGITS*4-1:0] frame;
    seg_pattern_t             seg;
    digit_sel_t               com;

    seg_pattern_t ref_seg [16];
    logic         row_enable [$];
    int           row_frames [$];
    int           row_extra [$];
    logic         row_advance [$];

    logic                     checking;
    logic [15:0]              seen_hex;
    digit_sel_t               prev_com;
    logic [`FND_DIGITS*4-1:0] prev_frame;
    logic [`FND_DIGITS*4-1:0] last_frame;
    hex_digit_t               nib;
    int                       run_len;
    logic                     first_run;
    int                       limit_ns;

    counter_display_top #(
        .COUNT_W      (20),
        .SCAN_DIV_BIT (2)
    ) dut (
        .clk          (clk),
        .reset_p      (reset_p),
        .count_enable (count_enable),
        .frame        (frame),
        .seg          (seg),
        .com          (com)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_seg(input string name, input seg_pattern_t expected,
                             input seg_pattern_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_com(input string name, input digit_sel_t expected,
                             input digit_sel_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_frame(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // position of the low common, bit 0 is the rightmost digit
    function automatic int lit_index(input digit_sel_t c);
        int idx;
        int i;
        idx = 0;
        for (i = 0; i < `FND_DIGITS; i++) begin
            if (c[i] == 1'b0) idx = i;
        end
        return idx;
    endfunction

    function automatic int low_count(input digit_sel_t c);
        int n;
        int i;
        n = 0;
        for (i = 0; i < `FND_DIGITS; i++) begin
            if (c[i] == 1'b0) n++;
        end
        return n;
    endfunction

    task automatic wait_wrap();
        while (com == `FND_COM_FIRST) @(negedge clk);
        while (com != `FND_COM_FIRST) @(negedge clk);   // next return to digit 0
    endtask

    task automatic wait_step();
        digit_sel_t start_com;
        start_com = com;
        while (com == start_com) @(negedge clk);
    endtask

    task automatic add_row(input logic en, input int base, input int extra, input logic adv);
        row_enable.push_back(en);
        row_frames.push_back(base + int'($urandom % 3));
        row_extra.push_back(extra);
        row_advance.push_back(adv);
    endtask

    // the first wrap of a row may hold a partial window, so steps are checked from the second
    task automatic run_row(input int r);
        logic [15:0] start_frame;
        logic [15:0] expected;
        int          w;
        start_frame = frame;
        @(posedge clk);
        count_enable <= row_enable[r];
        for (w = 0; w < row_frames[r]; w++) begin
            wait_wrap();
            if (w > 0) begin
                expected = row_advance[r] ? last_frame + 16'd2 : last_frame;
                check_frame("frame", expected, frame);
            end
            last_frame = frame;
        end
        for (w = 0; w < row_extra[r]; w++) begin
            wait_step();
        end
        if (row_advance[r] && !(frame > start_frame)) begin
            report_failure("frame did not advance while count_enable was high");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (checking) begin
            if (low_count(com) != 1) begin
                report_failure($sformatf("com %b does not have exactly one low bit", com));
            end
            nib = frame[lit_index(com)*4 +: 4];
            check_seg("seg", ref_seg[nib], seg);
            seen_hex[nib] = 1'b1;
            if (com != prev_com) begin
                if (com != {prev_com[2:0], prev_com[3]}) begin   // ring moves leftwards
                    report_failure($sformatf("com jumped from %b to %b", prev_com, com));
                end
                if (!first_run && run_len != COM_CYCLES) begin
                    report_failure($sformatf("com %b lasted %0d cycles", prev_com, run_len));
                end
                first_run = 1'b0;
                run_len = 1;
            end else begin
                run_len++;
                if (!first_run && run_len > COM_CYCLES) begin
                    report_failure($sformatf("com %b held too long", com));
                end
            end
            if (frame != prev_frame && !(com == `FND_COM_FIRST && prev_com != `FND_COM_FIRST)) begin
                report_failure("frame changed while the scan was not wrapping");
            end
            prev_com = com;
            prev_frame = frame;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout, the scenarios did not finish within %0d ns", limit_ns);
        $display("test failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int total;
        int r;
        void'($urandom(32'hddd6));
        clk = 1'b0;
        reset_p = 1'b1;
        count_enable = 1'b0;
        checking = 1'b0;
        seen_hex = '0;
        prev_com = `FND_COM_FIRST;
        prev_frame = '0;
        run_len = 0;
        first_run = 1'b1;
        limit_ns = 0;

        // glyphs a..g then dp, low lights; 7 keeps the f serif and 9 has no d tail
        ref_seg = '{8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49, 8'h41, 8'h1b,
                    8'h01, 8'h19, 8'h11, 8'hc1, 8'h63, 8'h85, 8'h61, 8'h71};

        // count_enable, base frames, extra scan steps, must advance
        add_row(1'b1, 10, 0, 1'b1);
        add_row(1'b0, 3, 0, 1'b0);
        add_row(1'b1, 10, 0, 1'b1);
        add_row(1'b0, 3, 2, 1'b0);   // half-frame hold flips the count phase
        add_row(1'b1, 10, 0, 1'b1);
        add_row(1'b0, 2, 1, 1'b0);
        add_row(1'b1, 6, 0, 1'b1);

        total = 4;
        for (r = 0; r < row_frames.size(); r++) begin
            total += row_frames[r] + row_extra[r] + 1;   // one frame of alignment per row
        end
        limit_ns = total * FRAME_CYCLES * CLK_PERIOD;

        repeat (2) @(posedge clk);
        reset_p <= 1'b0;
        @(negedge clk);
        check_com("com", `FND_COM_FIRST, com);
        check_frame("frame", 16'h0000, frame);
        check_seg("seg", ref_seg[0], seg);
        checking <= 1'b1;
        last_frame = frame;

        for (r = 0; r < row_frames.size(); r++) begin
            run_row(r);
        end

        if (seen_hex != 16'hffff) begin
            $display("not every hex value reached the display, seen mask %h", seen_hex);
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
